// ==== compile.f ====
source/mips_pkg.sv
source/decoder.sv
source/alu_ctrl.sv
source/alu.sv
source/reg_file.sv
source/data_mem.sv
source/cpu_top.sv
test/cpu_asserts.sv
test/tb_cpu.sv

// ==== Makefile ====
# Verilator build and run of the single-cycle core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_cpu, look for the pass line in $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module tb_cpu \
		--Mdir obj_dir -o tb_cpu
	./obj_dir/tb_cpu 2>&1 | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/tb_cpu.sv ====
// testbench for the single-cycle core, one table entry per fetched word
// table index is imem_addr_o / 4, a taken branch skips the entries it jumps over
// skipped slots expect no write, so fetching one by mistake stops the run
// two addi immediates are random, seed fixed at the start
`timescale 1ns/1ps

module tb_cpu;

	localparam int CLK_PERIOD  = 8;
	localparam int DRIVE_DLY   = 1;   // input drive after the rising edge
	localparam int NUM_ENTRIES = 32;
	localparam int TIMEOUT_NS  = (NUM_ENTRIES + 20) * CLK_PERIOD * 2;

	logic        clk_i;
	logic        rst_n_i;
	logic [31:0] imem_addr_o;
	logic [31:0] imem_data_i;
	logic        rf_we_o;
	logic [4:0]  rf_waddr_o;
	logic [31:0] rf_wdata_o;

	// program table, stimulus plus expected write port and next fetch
	logic [31:0] instr_tab [NUM_ENTRIES];
	logic [31:0] we_tab    [NUM_ENTRIES];
	logic [31:0] waddr_tab [NUM_ENTRIES];
	logic [31:0] wdata_tab [NUM_ENTRIES];
	logic [31:0] next_tab  [NUM_ENTRIES];
	string       name_tab  [NUM_ENTRIES];

	logic [31:0] rnd_a;  // random addi immediates, low 16 bits used
	logic [31:0] rnd_b;

	cpu_top u_cpu_top (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.imem_addr_o (imem_addr_o),
		.imem_data_i (imem_data_i),
		.rf_we_o     (rf_we_o),
		.rf_waddr_o  (rf_waddr_o),
		.rf_wdata_o  (rf_wdata_o)
	);

	bind cpu_top cpu_asserts u_cpu_asserts (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.imem_addr_i (imem_addr_o),
		.mem_read_i  (mem_read),
		.mem_write_i (mem_write),
		.branch_i    (branch),
		.rf_we_i     (rf_we_o)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	//----------------------------------------------------------------------
	// encoders and helpers
	//----------------------------------------------------------------------
	function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
			input logic [5:0] fn);
		return {mips_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
			input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] sext16(input logic [31:0] v);
		return {{16{v[15]}}, v[15:0]};  // immediate as the core sees it
	endfunction

	task automatic add_entry(input int idx, input string name, input logic [31:0] word,
			input int we, input int waddr, input logic [31:0] wdata, input int next);
		name_tab[idx]  = name;
		instr_tab[idx] = word;
		we_tab[idx]    = we;
		waddr_tab[idx] = waddr;
		wdata_tab[idx] = wdata;
		next_tab[idx]  = next;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s: expected 0x%08h, actual 0x%08h", what, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	//----------------------------------------------------------------------
	// program, register values noted as the table goes
	//----------------------------------------------------------------------
	task automatic build_table();
		logic [31:0] skip_word;
		skip_word = enc_i(mips_pkg::OP_ADDI, 0, 31, 16'h0BAD);  // must never run
		add_entry(0, "add r1 r0 r0", enc_r(0, 0, 1, mips_pkg::FN_ADD), 1, 1, 0, 4);
		add_entry(1, "addi r2 5", enc_i(mips_pkg::OP_ADDI, 0, 2, 5), 1, 2, 5, 8);
		add_entry(2, "addi r3 -3", enc_i(mips_pkg::OP_ADDI, 0, 3, -3), 1, 3, 32'hFFFF_FFFD, 12);
		add_entry(3, "addi r4 rnd", enc_i(mips_pkg::OP_ADDI, 0, 4, rnd_a), 1, 4,
			sext16(rnd_a), 16);
		add_entry(4, "addi r5 r4 rnd", enc_i(mips_pkg::OP_ADDI, 4, 5, rnd_b), 1, 5,
			sext16(rnd_a) + sext16(rnd_b), 20);
		add_entry(5, "add r6 r2 r3", enc_r(2, 3, 6, mips_pkg::FN_ADD), 1, 6, 2, 24);
		add_entry(6, "sub r7 r2 r3", enc_r(2, 3, 7, mips_pkg::FN_SUB), 1, 7, 8, 28);
		add_entry(7, "and r8 r2 r3", enc_r(2, 3, 8, mips_pkg::FN_AND), 1, 8, 5, 32);
		add_entry(8, "or r9 r2 r3", enc_r(2, 3, 9, mips_pkg::FN_OR), 1, 9, 32'hFFFF_FFFD, 36);
		add_entry(9, "slt r10 r3 r2", enc_r(3, 2, 10, mips_pkg::FN_SLT), 1, 10, 1, 40);  // -3 < 5
		add_entry(10, "slt r11 r2 r3", enc_r(2, 3, 11, mips_pkg::FN_SLT), 1, 11, 0, 44);
		add_entry(11, "bad funct r12", enc_r(2, 3, 12, 6'h26), 1, 12, 0, 48);
		// memory, words 2 and 3
		add_entry(12, "sw r2 8(r0)", enc_i(mips_pkg::OP_SW, 0, 2, 8), 0, 0, 0, 52);
		add_entry(13, "sw r3 12(r0)", enc_i(mips_pkg::OP_SW, 0, 3, 12), 0, 0, 0, 56);
		add_entry(14, "lw r13 8(r0)", enc_i(mips_pkg::OP_LW, 0, 13, 8), 1, 13, 5, 60);
		add_entry(15, "lw r14 12(r0)", enc_i(mips_pkg::OP_LW, 0, 14, 12), 1, 14,
			32'hFFFF_FFFD, 64);
		// branches, r2=5 r3=-3 r6=2 r7=8 r13=5
		add_entry(16, "beq not taken", enc_i(mips_pkg::OP_BEQ, 2, 6, 1), 0, 0, 0, 68);
		add_entry(17, "beq taken", enc_i(mips_pkg::OP_BEQ, 2, 13, 1), 0, 0, 0, 76);
		add_entry(18, "skipped slot", skip_word, 0, 0, 0, 0);
		add_entry(19, "bne not taken", enc_i(mips_pkg::OP_BNE, 2, 13, 1), 0, 0, 0, 80);
		add_entry(20, "bne taken", enc_i(mips_pkg::OP_BNE, 3, 2, 1), 0, 0, 0, 88);
		add_entry(21, "skipped slot", skip_word, 0, 0, 0, 0);
		add_entry(22, "bgt taken", enc_i(mips_pkg::OP_BGT, 2, 3, 1), 0, 0, 0, 96);
		add_entry(23, "skipped slot", skip_word, 0, 0, 0, 0);
		add_entry(24, "bgt not taken", enc_i(mips_pkg::OP_BGT, 3, 2, 1), 0, 0, 0, 100);
		// rt field set, bgez compares rs with 0 and not with rt
		add_entry(25, "bgez not taken", enc_i(mips_pkg::OP_BGEZ, 3, 3, 1), 0, 0, 0, 104);
		add_entry(26, "bgez taken", enc_i(mips_pkg::OP_BGEZ, 2, 7, 1), 0, 0, 0, 112);
		add_entry(27, "skipped slot", skip_word, 0, 0, 0, 0);
		// robustness
		add_entry(28, "unknown opcode", enc_i(6'h3F, 2, 3, 16), 0, 0, 0, 116);
		add_entry(29, "addi r0 77", enc_i(mips_pkg::OP_ADDI, 0, 0, 77), 1, 0, 77, 120);
		add_entry(30, "add r15 r0 r0", enc_r(0, 0, 15, mips_pkg::FN_ADD), 1, 15, 0, 124);
		add_entry(31, "add r16 r0 r2", enc_r(0, 2, 16, mips_pkg::FN_ADD), 1, 16, 5, 128);
	endtask

	//----------------------------------------------------------------------
	// reset, fetch and check loop
	//----------------------------------------------------------------------
	initial begin
		int idx;
		void'($urandom(32'h1633ac55));
		rnd_a = $urandom;
		rnd_b = $urandom;
		build_table();
		clk_i       = 1'b0;
		rst_n_i     = 1'b1;
		imem_data_i = '0;  // r0 = 0 + 0 while in reset
		#2 rst_n_i = 1'b0;  // clean falling edge for the async reset
		repeat (10) @(posedge clk_i);
		#DRIVE_DLY rst_n_i = 1'b1;
		check_value("reset pc", 32'd0, imem_addr_o);
		while (imem_addr_o < 32'(NUM_ENTRIES * 4)) begin
			idx = int'(imem_addr_o >> 2);
			imem_data_i = instr_tab[idx];
			#(CLK_PERIOD - DRIVE_DLY - 1);  // 1 ns before the edge
			check_value({name_tab[idx], " rf_we"}, we_tab[idx], {31'b0, rf_we_o});
			if (we_tab[idx][0]) begin
				check_value({name_tab[idx], " rf_waddr"}, waddr_tab[idx], {27'b0, rf_waddr_o});
				check_value({name_tab[idx], " rf_wdata"}, wdata_tab[idx], rf_wdata_o);
			end
			@(posedge clk_i);
			#DRIVE_DLY;
			check_value({name_tab[idx], " next pc"}, next_tab[idx], imem_addr_o);
		end
		$display("TEST PASSED");
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: program did not reach the end of the table in %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

endmodule

// ==== test/cpu_asserts.sv ====
// concurrent checks on the core, bound into cpu_top
// ports connect to the core's internal control nets
// checks pause while rst_n_i is low, except the reset pc check
`timescale 1ns/1ps

module cpu_asserts (
	input logic                        clk_i,
	input logic                        rst_n_i,
	input logic [mips_pkg::DATA_W-1:0] imem_addr_i,  // pc
	input logic                        mem_read_i,
	input logic                        mem_write_i,
	input logic                        branch_i,
	input logic                        rf_we_i
);

	// lw and sw never decode together
	a_mem_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(mem_read_i && mem_write_i))
		else $error("data memory read and write enabled together");

	a_pc_align: assert property (@(posedge clk_i) imem_addr_i[1:0] == 2'b00)
		else $error("fetch address not word aligned");

	// pc held at 0 in reset
	a_reset_pc: assert property (@(posedge clk_i) !rst_n_i |-> imem_addr_i == '0)
		else $error("fetch address not zero during reset");

	a_branch_no_wr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		branch_i |-> !rf_we_i)
		else $error("register write during a branch");

endmodule

// ==== source/cpu_top.sv ====
// single-cycle core, one instruction per clock, instruction memory is external
// imem_data_i must settle before the next rising edge of clk_i
// bgt decides from sign and zero of rs - rt, overflowing pairs decide wrongly
// no jumps, exceptions or hazards; data memory is not reset
`timescale 1ns/1ps

module cpu_top (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	output logic [mips_pkg::DATA_W-1:0] imem_addr_o,  // current pc
	input  logic [mips_pkg::DATA_W-1:0] imem_data_i,
	output logic                        rf_we_o,
	output logic [mips_pkg::REG_AW-1:0] rf_waddr_o,
	output logic [mips_pkg::DATA_W-1:0] rf_wdata_o
);

	logic [mips_pkg::DATA_W-1:0] pc;
	logic [mips_pkg::DATA_W-1:0] pc_plus4;
	logic [mips_pkg::DATA_W-1:0] br_target;
	logic [mips_pkg::DATA_W-1:0] pc_next;

	// instruction fields
	logic [mips_pkg::OP_W-1:0]   op;
	logic [mips_pkg::REG_AW-1:0] rs, rt, rd;
	logic [mips_pkg::FN_W-1:0]   funct;
	logic [15:0]                 imm;
	logic [mips_pkg::DATA_W-1:0] imm_ext;

	// control levels
	logic                         reg_dst, alu_src, reg_write, branch;
	logic [mips_pkg::BR_W-1:0]    branch_type;
	logic                         mem_read, mem_write, wb_from_mem, use_rt;
	logic [mips_pkg::ALUOP_W-1:0] alu_op;
	logic [mips_pkg::ALUFN_W-1:0] alu_fn;

	// data path
	logic [mips_pkg::DATA_W-1:0] rs_data, rt_data;
	logic [mips_pkg::DATA_W-1:0] alu_b, alu_result, mem_rdata;
	logic                        alu_zero, alu_neg;
	logic                        br_taken;

	assign op    = imem_data_i[31:26];
	assign rs    = imem_data_i[25:21];
	assign rt    = imem_data_i[20:16];
	assign rd    = imem_data_i[15:11];
	assign funct = imem_data_i[5:0];
	assign imm   = imem_data_i[15:0];

	assign imm_ext = {{(mips_pkg::DATA_W-16){imm[15]}}, imm};  // sign extend

	//----------------------------------------------------------------------
	// control
	//----------------------------------------------------------------------
	decoder u_decoder (
		.instr_op_i    (op),
		.reg_dst_o     (reg_dst),
		.alu_src_o     (alu_src),
		.reg_write_o   (reg_write),
		.branch_o      (branch),
		.branch_type_o (branch_type),
		.mem_read_o    (mem_read),
		.mem_write_o   (mem_write),
		.wb_from_mem_o (wb_from_mem),
		.use_rt_o      (use_rt),
		.alu_op_o      (alu_op)
	);

	alu_ctrl u_alu_ctrl (.alu_op_i(alu_op), .funct_i(funct), .alu_fn_o(alu_fn));

	//----------------------------------------------------------------------
	// register file, alu, data memory
	//----------------------------------------------------------------------
	reg_file u_reg_file (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.rs_addr_i (rs),
		.rt_addr_i (rt),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data),
		.we_i      (rf_we_o),
		.waddr_i   (rf_waddr_o),
		.wdata_i   (rf_wdata_o)
	);

	// b operand: immediate, else rt, else 0 for bgez
	assign alu_b = alu_src ? imm_ext : (use_rt ? rt_data : '0);

	alu u_alu (
		.a_i      (rs_data),
		.b_i      (alu_b),
		.alu_fn_i (alu_fn),
		.result_o (alu_result),
		.zero_o   (alu_zero),
		.neg_o    (alu_neg)
	);

	data_mem u_data_mem (
		.clk_i   (clk_i),
		.addr_i  (alu_result),  // rs + offset
		.wdata_i (rt_data),
		.we_i    (mem_write),
		.re_i    (mem_read),
		.rdata_o (mem_rdata)
	);

	// write back port, also seen outside
	assign rf_we_o    = reg_write;
	assign rf_waddr_o = reg_dst ? rd : rt;
	assign rf_wdata_o = wb_from_mem ? mem_rdata : alu_result;

	//----------------------------------------------------------------------
	// branch decision and next pc
	//----------------------------------------------------------------------
	always_comb begin
		case (branch_type)
			mips_pkg::BR_EQ:  br_taken = alu_zero;
			mips_pkg::BR_NE:  br_taken = !alu_zero;
			mips_pkg::BR_GT:  br_taken = !alu_zero && !alu_neg;
			mips_pkg::BR_GEZ: br_taken = !alu_neg;
			default:          br_taken = 1'b0;
		endcase
	end

	assign pc_plus4  = pc + 32'd4;
	assign br_target = pc_plus4 + {imm_ext[mips_pkg::DATA_W-3:0], 2'b00};  // offset * 4
	assign pc_next   = (branch && br_taken) ? br_target : pc_plus4;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc <= '0;
		end else begin
			pc <= pc_next;
		end
	end

	assign imem_addr_o = pc;

endmodule

// ==== source/data_mem.sv ====
// 64-word data memory, write on the rising edge, combinational read
// word index from addr bits 7:2, everything else ignored
// contents are not reset
`timescale 1ns/1ps

module data_mem (
	input  logic                        clk_i,
	input  logic [mips_pkg::DATA_W-1:0] addr_i,   // byte address
	input  logic [mips_pkg::DATA_W-1:0] wdata_i,
	input  logic                        we_i,
	input  logic                        re_i,
	output logic [mips_pkg::DATA_W-1:0] rdata_o   // 0 while re_i low
);

	logic [mips_pkg::DATA_W-1:0]  mem [mips_pkg::DMEM_WORDS];
	logic [mips_pkg::DMEM_AW-1:0] word_idx;

	assign word_idx = addr_i[mips_pkg::DMEM_AW+1:2];  // drop byte offset

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			mem[word_idx] <= wdata_i;
		end
	end

	assign rdata_o = re_i ? mem[word_idx] : '0;

endmodule

// ==== source/reg_file.sv ====
// 32 x 32 register file, two combinational reads, one write on the rising edge
// r0 reads as zero, writes to it are dropped
// no bypass: a read in the write cycle returns the old value
// async active-low reset clears every register
`timescale 1ns/1ps

module reg_file (
	input  logic                        clk_i,
	input  logic                        rst_n_i,
	input  logic [mips_pkg::REG_AW-1:0] rs_addr_i,
	input  logic [mips_pkg::REG_AW-1:0] rt_addr_i,
	output logic [mips_pkg::DATA_W-1:0] rs_data_o,
	output logic [mips_pkg::DATA_W-1:0] rt_data_o,
	input  logic                        we_i,
	input  logic [mips_pkg::REG_AW-1:0] waddr_i,
	input  logic [mips_pkg::DATA_W-1:0] wdata_i
);

	localparam int NREGS = 2 ** mips_pkg::REG_AW;

	logic [mips_pkg::DATA_W-1:0] regs [NREGS];

	//----------------------------------------------------------------------
	// write port
	//----------------------------------------------------------------------
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin  // r0 stays zero
			regs[waddr_i] <= wdata_i;
		end
	end

	// read ports
	assign rs_data_o = regs[rs_addr_i];
	assign rt_data_o = regs[rt_addr_i];

endmodule

// ==== source/alu.sv ====
// 32-bit alu, combinational
// flags come from the result, no overflow detection
// slt is signed and returns 1 or 0
`timescale 1ns/1ps

module alu (
	input  logic [mips_pkg::DATA_W-1:0]  a_i,
	input  logic [mips_pkg::DATA_W-1:0]  b_i,
	input  logic [mips_pkg::ALUFN_W-1:0] alu_fn_i,
	output logic [mips_pkg::DATA_W-1:0]  result_o,
	output logic                         zero_o,
	output logic                         neg_o
);

	logic slt_bit;  // signed a < b

	assign slt_bit = ($signed(a_i) < $signed(b_i));

	always_comb begin
		case (alu_fn_i)
			mips_pkg::ALU_AND:  result_o = a_i & b_i;
			mips_pkg::ALU_OR:   result_o = a_i | b_i;
			mips_pkg::ALU_ADD:  result_o = a_i + b_i;
			mips_pkg::ALU_SUB:  result_o = a_i - b_i;  // wraps on overflow
			mips_pkg::ALU_SLT:  result_o = {{(mips_pkg::DATA_W-1){1'b0}}, slt_bit};
			mips_pkg::ALU_ZERO: result_o = '0;
			default:            result_o = '0;
		endcase
	end

	// flags for the branch decision
	assign zero_o = (result_o == '0);
	assign neg_o  = result_o[mips_pkg::DATA_W-1];  // sign bit

endmodule

// ==== source/alu_ctrl.sv ====
// alu function select from the decoder class and the funct field
// an unknown funct on an R-type gives a zero result
`timescale 1ns/1ps

module alu_ctrl (
	input  logic [mips_pkg::ALUOP_W-1:0] alu_op_i,
	input  logic [mips_pkg::FN_W-1:0]    funct_i,
	output logic [mips_pkg::ALUFN_W-1:0] alu_fn_o
);

	always_comb begin
		case (alu_op_i)
			mips_pkg::ALUOP_RTYPE: begin
				case (funct_i)
					mips_pkg::FN_ADD: alu_fn_o = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: alu_fn_o = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_fn_o = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  alu_fn_o = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT: alu_fn_o = mips_pkg::ALU_SLT;
					default:          alu_fn_o = mips_pkg::ALU_ZERO;  // incl. word 0
				endcase
			end
			mips_pkg::ALUOP_ADD:  alu_fn_o = mips_pkg::ALU_ADD;   // addi, lw, sw
			mips_pkg::ALUOP_SUB:  alu_fn_o = mips_pkg::ALU_SUB;   // beq, bne, bgt
			mips_pkg::ALUOP_ZCMP: alu_fn_o = mips_pkg::ALU_SUB;   // bgez vs zero
			default:              alu_fn_o = mips_pkg::ALU_ZERO;  // ALUOP_NONE
		endcase
	end

endmodule

// ==== source/decoder.sv ====
// main control decoder, opcode only, purely combinational
// unknown opcodes drive every level low: no write, no branch, no memory access
// wb_from_mem_o is high for lw only
`timescale 1ns/1ps

module decoder (
	input  logic [mips_pkg::OP_W-1:0]    instr_op_i,
	output logic                         reg_dst_o,      // 1: rd, 0: rt
	output logic                         alu_src_o,      // 1: immediate operand
	output logic                         reg_write_o,
	output logic                         branch_o,
	output logic [mips_pkg::BR_W-1:0]    branch_type_o,
	output logic                         mem_read_o,
	output logic                         mem_write_o,
	output logic                         wb_from_mem_o,
	output logic                         use_rt_o,       // 0 for bgez, b operand is 0
	output logic [mips_pkg::ALUOP_W-1:0] alu_op_o
);

	always_comb begin
		// all low unless the opcode says otherwise
		reg_dst_o     = 1'b0;
		alu_src_o     = 1'b0;
		reg_write_o   = 1'b0;
		branch_o      = 1'b0;
		branch_type_o = mips_pkg::BR_EQ;
		mem_read_o    = 1'b0;
		mem_write_o   = 1'b0;
		wb_from_mem_o = 1'b0;
		use_rt_o      = 1'b0;
		alu_op_o      = mips_pkg::ALUOP_NONE;

		case (instr_op_i)
			mips_pkg::OP_RTYPE: begin
				reg_dst_o   = 1'b1;
				reg_write_o = 1'b1;
				use_rt_o    = 1'b1;
				alu_op_o    = mips_pkg::ALUOP_RTYPE;  // funct decides
			end
			mips_pkg::OP_ADDI: begin
				alu_src_o   = 1'b1;
				reg_write_o = 1'b1;
				use_rt_o    = 1'b1;
				alu_op_o    = mips_pkg::ALUOP_ADD;
			end
			mips_pkg::OP_LW: begin
				alu_src_o     = 1'b1;  // base + offset
				reg_write_o   = 1'b1;
				mem_read_o    = 1'b1;
				wb_from_mem_o = 1'b1;
				use_rt_o      = 1'b1;
				alu_op_o      = mips_pkg::ALUOP_ADD;
			end
			mips_pkg::OP_SW: begin
				alu_src_o   = 1'b1;
				mem_write_o = 1'b1;
				use_rt_o    = 1'b1;  // store data still read from rt
				alu_op_o    = mips_pkg::ALUOP_ADD;
			end

			//--------------------------------------------------------------
			// branches, compare through the alu subtract
			//--------------------------------------------------------------
			mips_pkg::OP_BEQ: begin
				branch_o      = 1'b1;
				branch_type_o = mips_pkg::BR_EQ;
				use_rt_o      = 1'b1;
				alu_op_o      = mips_pkg::ALUOP_SUB;
			end
			mips_pkg::OP_BNE: begin
				branch_o      = 1'b1;
				branch_type_o = mips_pkg::BR_NE;
				use_rt_o      = 1'b1;
				alu_op_o      = mips_pkg::ALUOP_SUB;
			end
			mips_pkg::OP_BGT: begin
				branch_o      = 1'b1;
				branch_type_o = mips_pkg::BR_GT;  // sign/zero of rs - rt
				use_rt_o      = 1'b1;
				alu_op_o      = mips_pkg::ALUOP_SUB;
			end
			mips_pkg::OP_BGEZ: begin
				branch_o      = 1'b1;
				branch_type_o = mips_pkg::BR_GEZ;
				alu_op_o      = mips_pkg::ALUOP_ZCMP;  // rs - 0, use_rt stays low
			end
			default: begin
				// keep the all-low defaults
			end
		endcase
	end

endmodule

// ==== source/mips_pkg.sv ====
// shared constants for the single-cycle MIPS-style core
// subset only: add sub and or slt addi lw sw beq bne bgt bgez
// jumps, lui, ori and slti are not decoded
// data memory decodes word bits 7:2, upper address bits are ignored
package mips_pkg;

	//----------------------------------------------------------------------
	// widths
	//----------------------------------------------------------------------
	localparam int DATA_W     = 32;  // data and instruction word
	localparam int REG_AW     = 5;   // register address
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // word index width
	localparam int OP_W       = 6;
	localparam int FN_W       = 6;
	localparam int ALUOP_W    = 3;   // decoder -> alu_ctrl class
	localparam int ALUFN_W    = 3;   // alu_ctrl -> alu function
	localparam int BR_W       = 2;

	//----------------------------------------------------------------------
	// opcodes, instr[31:26]
	//----------------------------------------------------------------------
	localparam logic [OP_W-1:0] OP_RTYPE = 6'h00;
	localparam logic [OP_W-1:0] OP_BGEZ  = 6'h01;
	localparam logic [OP_W-1:0] OP_BEQ   = 6'h04;
	localparam logic [OP_W-1:0] OP_BNE   = 6'h05;
	localparam logic [OP_W-1:0] OP_BGT   = 6'h07;
	localparam logic [OP_W-1:0] OP_ADDI  = 6'h08;
	localparam logic [OP_W-1:0] OP_LW    = 6'h23;
	localparam logic [OP_W-1:0] OP_SW    = 6'h2B;

	// funct field of R-type, instr[5:0]
	localparam logic [FN_W-1:0] FN_ADD = 6'h20;
	localparam logic [FN_W-1:0] FN_SUB = 6'h22;
	localparam logic [FN_W-1:0] FN_AND = 6'h24;
	localparam logic [FN_W-1:0] FN_OR  = 6'h25;
	localparam logic [FN_W-1:0] FN_SLT = 6'h2A;

	// alu class from decoder
	localparam logic [ALUOP_W-1:0] ALUOP_NONE  = 3'b000;
	localparam logic [ALUOP_W-1:0] ALUOP_SUB   = 3'b001;
	localparam logic [ALUOP_W-1:0] ALUOP_RTYPE = 3'b010;
	localparam logic [ALUOP_W-1:0] ALUOP_ZCMP  = 3'b101;  // bgez, rs - 0
	localparam logic [ALUOP_W-1:0] ALUOP_ADD   = 3'b110;

	// alu function select
	localparam logic [ALUFN_W-1:0] ALU_AND  = 3'd0;
	localparam logic [ALUFN_W-1:0] ALU_OR   = 3'd1;
	localparam logic [ALUFN_W-1:0] ALU_ADD  = 3'd2;
	localparam logic [ALUFN_W-1:0] ALU_SUB  = 3'd3;
	localparam logic [ALUFN_W-1:0] ALU_SLT  = 3'd4;
	localparam logic [ALUFN_W-1:0] ALU_ZERO = 3'd5;  // result forced to 0

	// branch condition type
	localparam logic [BR_W-1:0] BR_EQ  = 2'b00;
	localparam logic [BR_W-1:0] BR_GT  = 2'b01;
	localparam logic [BR_W-1:0] BR_GEZ = 2'b10;
	localparam logic [BR_W-1:0] BR_NE  = 2'b11;

endpackage
